/* logic/vram_pkg.sv */
package vram_pkg;

    // word and address widths shared by every region
    localparam int DATA_W = 16;
    localparam int ADDR_W = 11;  // widest region (pattern); narrower regions zero-extend

    // region select on the CPU and PPU side
    typedef enum logic [1:0] {
        TILE,
        PATTERN,
        PALETTE,
        SPRITE
    } region_t;

    // CPU write into the CPU-facing copy
    typedef struct packed {
        logic              wren;
        region_t           region;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
    } cpu_wr_t;

    // PPU read request against the PPU-facing copy
    typedef struct packed {
        region_t           region;
        logic [ADDR_W-1:0] addr;
    } ppu_rd_t;

    // one RAM port as seen from a copy engine
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              wren;
        logic [DATA_W-1:0] wrdata;
    } ram_req_t;

    // copy engine and coordinator FSM
    typedef enum logic {
        IDLE,
        COPY
    } copy_state_t;

endpackage : vram_pkg

/* logic/dp_ram.sv */
`timescale 1ns/1ps

module dp_ram #(
    parameter int AW = 10
) (
    input  logic                        clk,

    input  logic [AW-1:0]               addr_a,
    input  logic                        wren_a,
    input  logic [vram_pkg::DATA_W-1:0] wrdata_a,
    output logic [vram_pkg::DATA_W-1:0] rddata_a,

    input  logic [AW-1:0]               addr_b,
    input  logic                        wren_b,
    input  logic [vram_pkg::DATA_W-1:0] wrdata_b,
    output logic [vram_pkg::DATA_W-1:0] rddata_b
);
    import vram_pkg::*;

    localparam int DEPTH = 2 ** AW;

    logic [DATA_W-1:0] mem [DEPTH];

    // both ports share one process so the array has a single driver
    // reads see the old word when a port writes the same address (read-before-write)
    always_ff @(posedge clk) begin
        if (wren_a) begin
            mem[addr_a] <= wrdata_a;
        end
        if (wren_b) begin
            mem[addr_b] <= wrdata_b;
        end
        rddata_a <= mem[addr_a];  // one cycle latency
        rddata_b <= mem[addr_b];
    end

endmodule : dp_ram

/* logic/sync_writer.sv */
`timescale 1ns/1ps

module sync_writer #(
    parameter int HALF_AW = 10
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        sync,
    output logic                        done,

    input  logic [vram_pkg::DATA_W-1:0] rddata_from,
    output vram_pkg::ram_req_t          req_from,
    output vram_pkg::ram_req_t          req_to
);
    import vram_pkg::*;

    localparam logic [HALF_AW-1:0] LAST_ADDR = '1;

    copy_state_t        state;
    logic [HALF_AW-1:0] rd_addr;  // address presented to the source port
    logic [HALF_AW-1:0] wr_addr;  // trails rd_addr by one cycle
    logic               wr_pend;  // source data for wr_addr is on rddata_from

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= IDLE;
            rd_addr <= '0;
            wr_addr <= '0;
            wr_pend <= 1'b0;
        end else begin
            // every read issued in COPY turns into a write one cycle later
            wr_pend <= (state == COPY);
            wr_addr <= rd_addr;

            unique case (state)
                IDLE: begin
                    if (sync) begin
                        state   <= COPY;
                        rd_addr <= '0;
                    end
                end
                COPY: begin
                    rd_addr <= rd_addr + 1'b1;
                    if (rd_addr == LAST_ADDR) begin
                        state <= IDLE;  // last write still drains from wr_pend
                    end
                end
            endcase
        end
    end

    // high in the cycle of the final write
    assign done = wr_pend && (wr_addr == LAST_ADDR);

    always_comb begin
        req_from = '{addr: ADDR_W'(rd_addr), wren: 1'b0, wrdata: '0};  // source is read only
        req_to   = '{addr: ADDR_W'(wr_addr), wren: wr_pend, wrdata: rddata_from};
    end

endmodule : sync_writer

/* logic/vram_sync_writer.sv */
`timescale 1ns/1ps

module vram_sync_writer #(
    parameter int TIL_AW = 10,
    parameter int PAT_AW = 11,
    parameter int PAL_AW = 8,
    parameter int SPR_AW = 6
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  sync,
    output logic                                  done,
    output logic                                  busy,

    // indexed [region][half], half 0 on port a and half 1 on port b
    output vram_pkg::ram_req_t [3:0][1:0]         req_c,
    output vram_pkg::ram_req_t [3:0][1:0]         req_p,
    input  logic [3:0][1:0][vram_pkg::DATA_W-1:0] rddata_c
);
    import vram_pkg::*;

    // full address width per region, in region_t order
    localparam int REG_AW [4] = '{TIL_AW, PAT_AW, PAL_AW, SPR_AW};

    copy_state_t state;
    logic        start;     // sync accepted while idle
    logic [7:0]  eng_done;  // done pulses from the eight engines
    logic [7:0]  seen;      // latched engine completions

    // a sync strobe during a copy is ignored
    assign start = sync && (state == IDLE);

    for (genvar r = 0; r < 4; r++) begin : g_region
        for (genvar h = 0; h < 2; h++) begin : g_half
            localparam int HAW = REG_AW[r] - 1;

            ram_req_t from_req;
            ram_req_t to_req;

            sync_writer #(
                .HALF_AW(HAW)
            ) u_writer (
                .clk,
                .rst_n,
                .sync        (start),
                .done        (eng_done[2*r+h]),
                .rddata_from (rddata_c[r][h]),
                .req_from    (from_req),
                .req_to      (to_req)
            );

            // half select becomes the region address MSB
            assign req_c[r][h] = '{
                addr:   ADDR_W'({(h == 1), from_req.addr[HAW-1:0]}),
                wren:   from_req.wren,
                wrdata: from_req.wrdata
            };
            assign req_p[r][h] = '{
                addr:   ADDR_W'({(h == 1), to_req.addr[HAW-1:0]}),
                wren:   to_req.wren,
                wrdata: to_req.wrdata
            };
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            seen  <= '0;
        end else begin
            unique case (state)
                IDLE: begin
                    if (start) begin
                        state <= COPY;
                    end
                end
                COPY: begin
                    seen <= seen | eng_done;  // engines finish at different times
                    if (done) begin
                        // done is sampled here, so flags and busy drop together
                        state <= IDLE;
                        seen  <= '0;
                    end
                end
            endcase
        end
    end

    // one cycle after the slowest engine finishes
    assign done = &seen;
    assign busy = (state == COPY);

endmodule : vram_sync_writer

/* logic/vram_region.sv */
`timescale 1ns/1ps

module vram_region #(
    parameter int AW = 10
) (
    input  logic                             clk,
    input  logic                             busy,

    // CPU side, writes the C copy
    input  logic                             wr_en,
    input  logic [AW-1:0]                    wr_addr,
    input  logic [vram_pkg::DATA_W-1:0]      wr_data,

    // PPU side, reads the P copy
    input  logic [AW-1:0]                    rd_addr,
    output logic [vram_pkg::DATA_W-1:0]      rd_data,

    // copy engine ports, [0] lower half on port a, [1] upper half on port b
    input  vram_pkg::ram_req_t [1:0]         req_c,
    input  vram_pkg::ram_req_t [1:0]         req_p,
    output logic [1:0][vram_pkg::DATA_W-1:0] rddata_c
);
    import vram_pkg::*;

    ram_req_t c_a;  // C copy, port a
    ram_req_t c_b;
    ram_req_t p_a;  // P copy, port a
    ram_req_t p_b;

    logic [DATA_W-1:0] c_rd_a;
    logic [DATA_W-1:0] c_rd_b;

    // the copy owns all four ports while busy
    always_comb begin
        c_a = '{addr: ADDR_W'(wr_addr), wren: wr_en & ~busy, wrdata: wr_data};
        c_b = '0;
        p_a = '{addr: ADDR_W'(rd_addr), wren: 1'b0, wrdata: '0};
        p_b = '0;
        if (busy) begin
            c_a = req_c[0];
            c_b = req_c[1];
            p_a = req_p[0];
            p_b = req_p[1];
        end
    end

    dp_ram #(
        .AW(AW)
    ) u_ram_c (
        .clk,
        .addr_a   (c_a.addr[AW-1:0]),
        .wren_a   (c_a.wren),
        .wrdata_a (c_a.wrdata),
        .rddata_a (c_rd_a),
        .addr_b   (c_b.addr[AW-1:0]),
        .wren_b   (c_b.wren),
        .wrdata_b (c_b.wrdata),
        .rddata_b (c_rd_b)
    );

    dp_ram #(
        .AW(AW)
    ) u_ram_p (
        .clk,
        .addr_a   (p_a.addr[AW-1:0]),
        .wren_a   (p_a.wren),
        .wrdata_a (p_a.wrdata),
        .rddata_a (rd_data),  // only meaningful while busy is low
        .addr_b   (p_b.addr[AW-1:0]),
        .wren_b   (p_b.wren),
        .wrdata_b (p_b.wrdata),
        .rddata_b ()
    );

    assign rddata_c = {c_rd_b, c_rd_a};

endmodule : vram_region

/* logic/vram_sync_top.sv */
`timescale 1ns/1ps

module vram_sync_top #(
    parameter int TIL_AW = 10,
    parameter int PAT_AW = 11,
    parameter int PAL_AW = 8,
    parameter int SPR_AW = 6
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        sync,
    input  vram_pkg::cpu_wr_t           cpu_wr,
    input  vram_pkg::ppu_rd_t           ppu_rd,
    output logic [vram_pkg::DATA_W-1:0] ppu_rd_data,
    output logic                        done,
    output logic                        busy
);
    import vram_pkg::*;

    localparam int REG_AW [4] = '{TIL_AW, PAT_AW, PAL_AW, SPR_AW};

    ram_req_t [3:0][1:0]          req_c;
    ram_req_t [3:0][1:0]          req_p;
    logic [3:0][1:0][DATA_W-1:0]  rddata_c;
    logic [3:0][DATA_W-1:0]       rd_data;   // per region P copy read data
    region_t                      rd_sel;    // region of the read now returning

    for (genvar r = 0; r < 4; r++) begin : g_region
        localparam int AW = REG_AW[r];

        vram_region #(
            .AW(AW)
        ) u_region (
            .clk,
            .busy,
            .wr_en    (cpu_wr.wren && (cpu_wr.region == region_t'(r))),
            .wr_addr  (cpu_wr.addr[AW-1:0]),
            .wr_data  (cpu_wr.data),
            .rd_addr  (ppu_rd.addr[AW-1:0]),
            .rd_data  (rd_data[r]),
            .req_c    (req_c[r]),
            .req_p    (req_p[r]),
            .rddata_c (rddata_c[r])
        );
    end

    vram_sync_writer #(
        .TIL_AW(TIL_AW),
        .PAT_AW(PAT_AW),
        .PAL_AW(PAL_AW),
        .SPR_AW(SPR_AW)
    ) u_sync (
        .clk,
        .rst_n,
        .sync,
        .done,
        .busy,
        .req_c,
        .req_p,
        .rddata_c
    );

    // RAM read latency is one cycle, so the select follows one cycle behind
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_sel <= TILE;
        end else begin
            rd_sel <= ppu_rd.region;
        end
    end

    assign ppu_rd_data = rd_data[rd_sel];

endmodule : vram_sync_top

/* test/vram_sync_sva.sv */
`timescale 1ns/1ps

module vram_sync_sva (
    input logic                         clk,
    input logic                         rst_n,
    input logic                         sync,
    input logic                         done,
    input logic                         busy,
    input vram_pkg::ram_req_t [3:0][1:0] req_p
);
    import vram_pkg::*;

    logic any_wren;  // some engine writes a PPU copy

    always_comb begin
        any_wren = 1'b0;
        for (int r = 0; r < 4; r++) begin
            for (int h = 0; h < 2; h++) begin
                any_wren = any_wren | req_p[r][h].wren;
            end
        end
    end

    a_done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done) else $error("done held high for two cycles");

    // accepted sync means the coordinator was idle
    a_busy_rise: assert property (@(posedge clk) disable iff (!rst_n)
        sync && !busy |=> busy) else $error("busy did not rise after sync");

    a_busy_fall: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !busy) else $error("busy still high after done");

    a_no_write_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !busy |-> !any_wren) else $error("engine write enable high while idle");

endmodule : vram_sync_sva

bind vram_sync_writer vram_sync_sva u_sva (
    .clk,
    .rst_n,
    .sync,
    .done,
    .busy,
    .req_p
);

/* test/vram_sync_tb.sv */
`timescale 1ns/1ps

module vram_sync_tb;
    import vram_pkg::*;

    localparam int TIL_AW       = 10;
    localparam int PAT_AW       = 11;
    localparam int PAL_AW       = 8;
    localparam int SPR_AW       = 6;
    localparam int DONE_TIMEOUT = 4000;  // a copy takes about 1026 cycles
    localparam int NEW_WRITES   = 64;
    localparam int BUSY_WRITES  = 100;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              sync;
    cpu_wr_t           cpu_wr;
    ppu_rd_t           ppu_rd;
    logic [DATA_W-1:0] ppu_rd_data;
    logic              done;
    logic              busy;

    // reference copies, indexed [region][address]
    logic [DATA_W-1:0] model_c [4][2048];
    logic [DATA_W-1:0] model_p [4][2048];

    integer seed            = 32'h1399_da8f;
    bit     copy_running    = 1'b0;  // set from the sync strobe until done
    int     errors          = 0;
    int     errors_at_start = 0;
    int     pass_count      = 0;
    int     fail_count      = 0;

    vram_sync_top #(
        .TIL_AW(TIL_AW),
        .PAT_AW(PAT_AW),
        .PAL_AW(PAL_AW),
        .SPR_AW(SPR_AW)
    ) UUT (
        .clk,
        .rst_n,
        .sync,
        .cpu_wr,
        .ppu_rd,
        .ppu_rd_data,
        .done,
        .busy
    );

    always #5 clk = ~clk;

    function automatic int region_words(input int r);
        int aw;
        case (r)
            0:       aw = TIL_AW;
            1:       aw = PAT_AW;
            2:       aw = PAL_AW;
            default: aw = SPR_AW;
        endcase
        return 1 << aw;
    endfunction

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("mismatch %s: expected %h actual %h", what, expected, actual);
        end
    endtask

    task automatic end_test(input string name);
        if (errors == errors_at_start) begin
            pass_count++;
            $display("test %s: ok", name);
        end else begin
            fail_count++;
            $display("test %s: failed with %0d errors", name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    // captured at the next edge, dropped by the DUT while a copy runs
    task automatic write_word(input int r, input int a, input logic [DATA_W-1:0] d);
        @(posedge clk);
        cpu_wr <= '{wren: 1'b1, region: region_t'(r), addr: ADDR_W'(a), data: d};
        if (!copy_running) begin
            model_c[r][a] = d;
        end
    endtask

    task automatic end_writes;
        @(posedge clk);
        cpu_wr <= '0;
    endtask

    task automatic pulse_sync;
        @(posedge clk);
        sync <= 1'b1;
        @(posedge clk);
        sync <= 1'b0;  // the DUT samples the strobe at this edge
        copy_running = 1'b1;
    endtask

    task automatic wait_done(input string name);
        int cycles;
        bit seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < DONE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            check({name, " busy during copy"}, 32'd1, 32'(busy));
            if (done) begin
                seen = 1'b1;
            end
        end
        if (!seen) begin
            errors++;
            $display("timeout: no done pulse within %0d cycles in %s", DONE_TIMEOUT, name);
        end else begin
            for (int r = 0; r < 4; r++) begin
                for (int a = 0; a < region_words(r); a++) begin
                    model_p[r][a] = model_c[r][a];
                end
            end
            copy_running = 1'b0;
            @(negedge clk);
            check({name, " busy after done"}, 32'd0, 32'(busy));
            check({name, " done width"}, 32'd0, 32'(done));
        end
    endtask

    // data returns one cycle after the request is sampled
    task automatic read_check(input string name, input int r, input int a);
        @(posedge clk);
        ppu_rd <= '{region: region_t'(r), addr: ADDR_W'(a)};
        @(posedge clk);
        @(negedge clk);
        check($sformatf("%s region %0d addr %h", name, r, a),
              32'(model_p[r][a]), 32'(ppu_rd_data));
    endtask

    task automatic read_all(input string name);
        for (int r = 0; r < 4; r++) begin
            for (int a = 0; a < region_words(r); a++) begin
                read_check(name, r, a);
            end
        end
    endtask

    initial begin
        int r;
        int a;
        int n;
        int ra [$];
        int aa [$];
        rst_n  = 1'b0;
        sync   = 1'b0;
        cpu_wr = '0;
        ppu_rd = '0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        repeat (20) begin
            @(negedge clk);
            check("reset done", 32'd0, 32'(done));
            check("reset busy", 32'd0, 32'(busy));
        end
        end_test("reset");

        for (r = 0; r < 4; r++) begin
            for (a = 0; a < region_words(r); a++) begin
                write_word(r, a, DATA_W'($random(seed)));
            end
        end
        end_writes;
        pulse_sync;
        wait_done("isolation first sync");
        for (n = 0; n < NEW_WRITES; n++) begin
            r = $random(seed) & 3;
            a = $random(seed) & (region_words(r) - 1);
            write_word(r, a, DATA_W'($random(seed)));
            ra.push_back(r);
            aa.push_back(a);
        end
        end_writes;
        for (n = 0; n < ra.size(); n++) begin
            read_check("isolation", ra[n], aa[n]);  // still the first sync's data
        end
        end_test("isolation");

        pulse_sync;
        wait_done("full copy");
        read_all("full copy");
        end_test("full copy");

        pulse_sync;
        for (n = 0; n < BUSY_WRITES; n++) begin
            r = $random(seed) & 3;
            a = $random(seed) & (region_words(r) - 1);
            write_word(r, a, DATA_W'($random(seed)));
        end
        end_writes;
        wait_done("dropped writes copy");
        pulse_sync;
        wait_done("dropped writes second sync");
        read_all("dropped writes");
        end_test("dropped writes");

        pulse_sync;
        for (n = 0; n < 100; n++) begin
            @(negedge clk);
            check("protocol busy", 32'd1, 32'(busy));
            check("protocol early done", 32'd0, 32'(done));
        end
        pulse_sync;  // lands while busy and must not start a second copy
        wait_done("protocol");
        n = 0;
        repeat (1100) begin
            @(negedge clk);
            if (done) begin
                n++;
            end
            check("protocol idle busy", 32'd0, 32'(busy));
        end
        check("protocol extra done pulses", 32'd0, 32'(n));
        end_test("protocol");

        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule : vram_sync_tb

/* sim.f */
logic/vram_pkg.sv
logic/dp_ram.sv
logic/sync_writer.sv
logic/vram_sync_writer.sv
logic/vram_region.sv
logic/vram_sync_top.sv
test/vram_sync_sva.sv
test/vram_sync_tb.sv

/* Makefile */
# Verilator build and run for the VRAM sync testbench
# any variable can be overridden, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= vram_sync_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run $(TOP), search $(LOG) for the fail message"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "RESULT: FAIL" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
